//--- include/datapath_settings.svh
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

`define WORD_WIDTH 32   // bus and register width
`define REG_COUNT  16   // general purpose registers

// ALU operation codes, five bits wide
`define OP_NOT 5'd1
`define OP_ADD 5'd2
`define OP_SUB 5'd3
`define OP_AND 5'd4
`define OP_OR  5'd5
`define OP_NEG 5'd6
`define OP_SHL 5'd7
`define OP_SHR 5'd8
`define OP_MUL 5'd9

`endif

//--- hw/datapath_pkg.sv
`include "datapath_settings.svh"

package datapath_pkg;

   typedef logic [`WORD_WIDTH-1:0]         word_t;
   typedef logic [2*`WORD_WIDTH-1:0]       product_t;   // high half to ZHI, low half to ZLO
   typedef logic [$clog2(`REG_COUNT)-1:0]  regIndex_t;
   typedef logic [4:0]                     aluOp_t;

   // bus drive requests, earlier fields win when several are set
   typedef struct packed {
      logic rfOut;
      logic pcOut;
      logic irOut;
      logic yOut;
      logic zLoOut;
      logic zHiOut;
      logic marOut;
      logic hiOut;
      logic loOut;
      logic mdrOut;
   } busSources_t;

   typedef struct packed {
      logic rfIn;
      logic pcIn;
      logic irIn;
      logic yIn;
      logic zIn;
      logic marIn;
      logic hiIn;
      logic loIn;
      logic mdrIn;
      logic read;   // MDR takes memory input instead of bus
   } regLoads_t;

   typedef enum logic [1:0] {
      Idle,
      Multiply,
      Done
   } aluState_t;

endpackage

//--- hw/registerFile.sv
`timescale 1ns/1ps
`include "datapath_settings.svh"

// sixteen general purpose registers
// one write port and one read port share the same select
module registerFile import datapath_pkg::*; (
   input  logic      Clock,
   input  logic      reset,
   input  logic      writeEnable,
   input  regIndex_t regSelect,
   input  word_t     writeData,
   output word_t     readData
);

   word_t regs [`REG_COUNT];

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEnable) begin
         regs[regSelect] <= writeData;   // bus word into selected entry
      end
   end

   // read side feeds the bus multiplexer directly
   assign readData = regs[regSelect];

endmodule

//--- hw/busRegisterBank.sv
`timescale 1ns/1ps
`include "datapath_settings.svh"

// special purpose registers and the bus source multiplexer
module busRegisterBank import datapath_pkg::*; (
   input  logic        Clock,
   input  logic        reset,
   input  busSources_t sources,
   input  regLoads_t   loads,
   input  word_t       rfData,
   input  word_t       memDataIn,
   input  product_t    aluResult,
   input  logic        aluDone,
   output word_t       yValue,
   output word_t       bus
);

   word_t pc;
   word_t ir;
   word_t y;
   word_t zHi;
   word_t zLo;
   word_t mar;
   word_t hi;
   word_t lo;
   word_t mdr;

   // registers that only ever load from the bus
   always_ff @(posedge Clock) begin
      if (reset) begin
         pc  <= '0;
         ir  <= '0;
         y   <= '0;
         mar <= '0;
         hi  <= '0;
         lo  <= '0;
      end else begin
         if (loads.pcIn) pc <= bus;
         if (loads.irIn) ir <= bus;      // no decode, just held for the sequencer
         if (loads.yIn) y <= bus;
         if (loads.marIn) mar <= bus;
         if (loads.hiIn) hi <= bus;
         if (loads.loIn) lo <= bus;
      end
   end

   // Z pair captures the ALU result only while the done pulse is high.
   // A result finishing with zIn low is simply dropped.
   always_ff @(posedge Clock) begin
      if (reset) begin
         zHi <= '0;
         zLo <= '0;
      end else if (aluDone && loads.zIn) begin
         zHi <= aluResult[`WORD_WIDTH +: `WORD_WIDTH];
         zLo <= aluResult[0 +: `WORD_WIDTH];
      end
   end

   // memory data register
   always_ff @(posedge Clock) begin
      if (reset) begin
         mdr <= '0;
      end else if (loads.mdrIn) begin
         if (loads.read) begin
            mdr <= memDataIn;   // memory read
         end else begin
            mdr <= bus;         // write-back path from bus
         end
      end
   end

   // priority follows the field order of busSources_t
   always_comb begin
      if (sources.rfOut) begin
         bus = rfData;
      end else if (sources.pcOut) begin
         bus = pc;
      end else if (sources.irOut) begin
         bus = ir;
      end else if (sources.yOut) begin
         bus = y;
      end else if (sources.zLoOut) begin
         bus = zLo;
      end else if (sources.zHiOut) begin
         bus = zHi;
      end else if (sources.marOut) begin
         bus = mar;
      end else if (sources.hiOut) begin
         bus = hi;
      end else if (sources.loOut) begin
         bus = lo;
      end else if (sources.mdrOut) begin
         bus = mdr;
      end else begin
         bus = '0;   // idle bus reads zero
      end
   end

   assign yValue = y;   // ALU A operand

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`include "datapath_settings.svh"

// ALU with start/done handshake
// most ops take one cycle, multiply is a 32 step shift-add
module aluUnit import datapath_pkg::*; (
   input  logic     Clock,
   input  logic     reset,
   input  logic     start,
   input  aluOp_t   aluOp,
   input  word_t    operandA,
   input  word_t    operandB,
   output product_t result,
   output logic     done
);

   aluState_t state;
   product_t  multiplicand;   // shifted left each step
   word_t     multiplier;     // shifted right each step
   logic [4:0] stepCount;

   function automatic product_t singleCycle(aluOp_t op, word_t a, word_t b);
      word_t r;
      case (op)
         `OP_NOT: r = ~b;
         `OP_NEG: r = -b;
         `OP_ADD: r = a + b;
         `OP_SUB: r = a - b;
         `OP_AND: r = a & b;
         `OP_OR:  r = a | b;
         `OP_SHL: r = a << b[4:0];
         `OP_SHR: r = a >> b[4:0];   // logical
         default: r = '0;
      endcase
      return product_t'(r);   // zero extended
   endfunction

   always_ff @(posedge Clock) begin
      if (reset) begin
         state     <= Idle;
         stepCount <= '0;
         result    <= '0;
      end else begin
         case (state)
            Idle: begin
               if (start) begin
                  if (aluOp == `OP_MUL) begin
                     multiplicand <= product_t'(operandA);
                     multiplier   <= operandB;
                     result       <= '0;
                     stepCount    <= '0;
                     state        <= Multiply;
                  end else begin
                     result <= singleCycle(aluOp, operandA, operandB);
                     state  <= Done;
                  end
               end
            end
            Multiply: begin
               if (multiplier[0]) begin
                  result <= result + multiplicand;   // add partial product
               end
               multiplicand <= multiplicand << 1;
               multiplier   <= multiplier >> 1;
               stepCount    <= stepCount + 5'd1;
               if (stepCount == 5'd31) begin
                  state <= Done;   // last of 32 steps
               end
            end
            Done: begin
               state <= Idle;   // one cycle pulse only
            end
            default: begin
               state <= Idle;
            end
         endcase
      end
   end

   assign done = (state == Done);

endmodule

//--- hw/DataPath.sv
`timescale 1ns/1ps

// single bus datapath, sequenced from outside
module DataPath import datapath_pkg::*; (
   input  logic        Clock,
   input  logic        reset,
   input  busSources_t sources,
   input  regLoads_t   loads,
   input  regIndex_t   regSelect,
   input  aluOp_t      aluOp,
   input  logic        start,
   input  word_t       memDataIn,
   output word_t       bus,
   output logic        finished
);

   word_t    rfData;      // register file read word
   word_t    yValue;      // Y register to ALU
   product_t aluResult;

   registerFile regFile (
      .Clock       (Clock),
      .reset       (reset),
      .writeEnable (loads.rfIn),
      .regSelect   (regSelect),
      .writeData   (bus),
      .readData    (rfData)
   );

   busRegisterBank regBank (
      .Clock     (Clock),
      .reset     (reset),
      .sources   (sources),
      .loads     (loads),
      .rfData    (rfData),
      .memDataIn (memDataIn),
      .aluResult (aluResult),
      .aluDone   (finished),   // Z loads on the done pulse
      .yValue    (yValue),
      .bus       (bus)
   );

   aluUnit alu (
      .Clock    (Clock),
      .reset    (reset),
      .start    (start),
      .aluOp    (aluOp),
      .operandA (yValue),
      .operandB (bus),
      .result   (aluResult),
      .done     (finished)
   );

endmodule

//--- test/DataPath_chk.sv
`timescale 1ns/1ps
`include "datapath_settings.svh"

// handshake checks, bound into the ALU
module DataPath_chk import datapath_pkg::*; (
   input logic      Clock,
   input logic      reset,
   input logic      start,
   input aluOp_t    aluOp,
   input aluState_t state,
   input logic      done
);

   int assertFailures = 0;   // read by the testbench at the end

   // done is a one cycle pulse
   assert property (@(posedge Clock) disable iff (reset) done |=> !done)
      else begin
         assertFailures++;
         $error("done stayed high for two cycles");
      end

   assert property (@(posedge Clock) reset |=> !done)
      else begin
         assertFailures++;
         $error("done high in the cycle after reset");
      end

   // single cycle operations answer on the next cycle
   assert property (@(posedge Clock) disable iff (reset)
         (state == Idle && start && aluOp != `OP_MUL) |=> done)
      else begin
         assertFailures++;
         $error("no done one cycle after a single cycle start");
      end

endmodule

bind aluUnit DataPath_chk handshakeChk (
   .Clock (Clock),
   .reset (reset),
   .start (start),
   .aluOp (aluOp),
   .state (state),
   .done  (done)
);

//--- test/DataPath_tb.sv
`timescale 1ns/1ps
`include "datapath_settings.svh"

module DataPath_tb import datapath_pkg::*; ();

   typedef struct {
      busSources_t src;
      regLoads_t   ld;
      regIndex_t   sel;
      aluOp_t      op;
      int          latency;    // cycles from start to finished, 0 for plain moves
      word_t       mem;
      logic        check;
      word_t       expected;
      int          test;
   } step_t;

   localparam busSources_t noSrc  = '0;
   localparam busSources_t srcMdr = '{mdrOut: 1'b1, default: 1'b0};
   localparam busSources_t srcRf  = '{rfOut: 1'b1, default: 1'b0};
   localparam busSources_t srcZLo = '{zLoOut: 1'b1, default: 1'b0};
   localparam busSources_t srcZHi = '{zHiOut: 1'b1, default: 1'b0};
   localparam regLoads_t   noLd   = '0;
   localparam regLoads_t   ldMem  = '{mdrIn: 1'b1, read: 1'b1, default: 1'b0};
   localparam regLoads_t   ldY    = '{yIn: 1'b1, default: 1'b0};
   localparam regLoads_t   ldRf   = '{rfIn: 1'b1, default: 1'b0};
   localparam regLoads_t   ldZ    = '{zIn: 1'b1, default: 1'b0};

   logic        Clock;
   logic        reset;
   busSources_t sources;
   regLoads_t   loads;
   regIndex_t   regSelect;
   aluOp_t      aluOp;
   logic        start;
   word_t       memDataIn;
   word_t       bus;
   logic        finished;

   step_t steps[$];
   int    currentTest;
   word_t lcgState;
   logic  tableReady = 1'b0;
   int    passCount = 0;
   int    failCount = 0;
   int    failsBefore = 0;
   string testNames[6] = '{"reset values", "memory load", "NOT sequence",
                           "single cycle ops", "multiply", "uncaptured result"};

   DataPath dut (.*);

   always #10 Clock = ~Clock;

   function automatic word_t nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // expected ALU output straight from the operation rules
   function automatic product_t modelResult(aluOp_t op, word_t a, word_t b);
      case (op)
         `OP_NOT: return {32'b0, ~b};
         `OP_NEG: return {32'b0, 32'd0 - b};
         `OP_ADD: return {32'b0, a + b};
         `OP_SUB: return {32'b0, a - b};
         `OP_AND: return {32'b0, a & b};
         `OP_OR:  return {32'b0, a | b};
         `OP_SHL: return {32'b0, a << b[4:0]};
         `OP_SHR: return {32'b0, a >> b[4:0]};
         `OP_MUL: return {32'b0, a} * {32'b0, b};   // unsigned 64 bit product
         default: return '0;
      endcase
   endfunction

   function automatic void addStep(busSources_t src, regLoads_t ld, regIndex_t sel,
                                   aluOp_t op, int lat, word_t mem, logic chk, word_t exp);
      steps.push_back('{src, ld, sel, op, lat, mem, chk, exp, currentTest});
   endfunction

   function automatic void moveStep(busSources_t src, regLoads_t ld, regIndex_t sel);
      addStep(src, ld, sel, '0, 0, '0, 1'b0, '0);
   endfunction

   function automatic void checkBus(busSources_t src, regIndex_t sel, word_t exp);
      addStep(src, noLd, sel, '0, 0, '0, 1'b1, exp);
   endfunction

   // Y gets a, MDR is left holding b for the bus
   function automatic void runOp(aluOp_t op, word_t a, word_t b, logic capture);
      product_t p;
      p = modelResult(op, a, b);
      addStep(noSrc, ldMem, '0, '0, 0, a, 1'b0, '0);
      moveStep(srcMdr, ldY, '0);
      addStep(noSrc, ldMem, '0, '0, 0, b, 1'b0, '0);
      addStep(srcMdr, capture ? ldZ : noLd, '0, op, (op == `OP_MUL) ? 33 : 1, '0, 1'b0, '0);
      if (capture) begin
         checkBus(srcZLo, '0, p[31:0]);
         checkBus(srcZHi, '0, p[63:32]);   // zero for all but multiply
      end
   endfunction

   function automatic void buildTable();
      aluOp_t   ops[7] = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_NEG, `OP_SHL, `OP_SHR};
      word_t    a;
      word_t    b;
      product_t p;
      lcgState = 32'h1c4b;
      currentTest = 0;
      for (int k = 0; k < 9; k++) checkBus(busSources_t'(10'b1 << k), '0, '0);
      currentTest = 1;
      addStep(noSrc, ldMem, '0, '0, 0, 32'h12, 1'b0, '0);
      moveStep(srcMdr, ldRf, 4'd7);
      addStep(noSrc, ldMem, '0, '0, 0, 32'h18, 1'b0, '0);
      moveStep(srcMdr, ldRf, 4'd6);
      checkBus(srcRf, 4'd7, 32'h12);
      checkBus(srcRf, 4'd6, 32'h18);
      currentTest = 2;
      moveStep(srcRf, ldY, 4'd7);
      addStep(srcRf, ldZ, 4'd7, `OP_NOT, 1, '0, 1'b0, '0);
      moveStep(srcZLo, ldRf, 4'd6);
      checkBus(srcRf, 4'd6, 32'hFFFF_FFED);
      currentTest = 3;
      foreach (ops[i]) begin
         runOp(ops[i], 32'h0000_f0f0, 32'h0000_0013, 1'b1);
         a = nextRandom();
         b = nextRandom();
         runOp(ops[i], a, b, 1'b1);
      end
      currentTest = 4;
      a = nextRandom();
      b = nextRandom();
      runOp(`OP_MUL, a, b, 1'b1);
      p = modelResult(`OP_MUL, a, b);
      currentTest = 5;
      runOp(`OP_ADD, 32'h1, 32'h2, 1'b0);   // zIn low, result dropped
      checkBus(srcZLo, '0, p[31:0]);
   endfunction

   task automatic applyStep(step_t s);
      int waited;
      waited = 0;
      @(posedge Clock);
      sources   <= s.src;
      loads     <= s.ld;
      regSelect <= s.sel;
      aluOp     <= s.op;
      start     <= (s.latency != 0);
      memDataIn <= s.mem;
      @(negedge Clock);
      if (s.latency != 0) begin
         while (finished !== 1'b1) begin
            @(posedge Clock);
            start <= (s.op == `OP_MUL && waited == 4);   // stray start while busy
            waited++;
            @(negedge Clock);
         end
         assert (waited == s.latency) passCount++;
         else begin
            $display("test %0d: finished came %0d cycles after start instead of %0d",
                     s.test, waited, s.latency);
            failCount++;
         end
      end else begin
         assert (finished === 1'b0) passCount++;
         else begin
            $display("test %0d: finished was high with no ALU operation running", s.test);
            failCount++;
         end
         if (s.check) begin
            assert (bus === s.expected) passCount++;
            else begin
               $display("Mismatch at time %0t: test %0d bus %h, expected %h",
                        $time, s.test, bus, s.expected);
               failCount++;
            end
         end
      end
   endtask

   initial begin
      Clock     = 1'b0;
      reset     = 1'b1;
      sources   = '0;
      loads     = '0;
      regSelect = '0;
      aluOp     = '0;
      start     = 1'b0;
      memDataIn = '0;
      buildTable();
      tableReady = 1'b1;
      repeat (8) @(posedge Clock);
      reset <= 1'b0;
      for (int i = 0; i < steps.size(); i++) begin
         applyStep(steps[i]);
         if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
            $display("test %0d (%s) done, %0d errors", steps[i].test,
                     testNames[steps[i].test], failCount - failsBefore);
            failsBefore = failCount;
         end
      end
      failCount += dut.alu.handshakeChk.assertFailures;
      $display("checks passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // watchdog scaled by table length
   initial begin
      wait (tableReady);
      #((steps.size() * 40 + 2000) * 20);
      $display("timeout: the step table did not complete in time");
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- tb.f
+incdir+include
hw/datapath_pkg.sv
hw/registerFile.sv
hw/busRegisterBank.sv
hw/aluUnit.sv
hw/DataPath.sv
test/DataPath_chk.sv
test/DataPath_tb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - include_dirs:
      - include
    files:
      - hw/datapath_pkg.sv
      - hw/registerFile.sv
      - hw/busRegisterBank.sv
      - hw/aluUnit.sv
      - hw/DataPath.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/DataPath_chk.sv
      - test/DataPath_tb.sv
